/* verilog/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	localparam int NUM_REGS = 32;
	localparam int DATA_W = 32;

	typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] uint32_t;
	typedef logic [31:0] virt_t;

	typedef enum logic [2:0] {
		FU_ALU = 3'd0,
		FU_MUL = 3'd1,
		FU_CP0 = 3'd2,
		FU_STORE = 3'd3
	} fu_t;

	// internal cause encoding where zero means no exception
	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_INT = 5'd1,
		EXC_ADES = 5'd5,
		EXC_SYS = 5'd8,
		EXC_OV = 5'd12
	} exc_code_t;

	localparam virt_t EXC_VECTOR = 32'hBFC00380;

endpackage

`default_nettype wire

/* verilog/rob_pkg.sv */
`default_nettype none

package rob_pkg;

	// entry pairs in the reorder buffer
	localparam int ROB_DEPTH = 8;
	localparam int ROB_PTR_W = $clog2(ROB_DEPTH);

	typedef logic [ROB_PTR_W-1:0] rob_index_t;

	localparam int STQ_DEPTH = 4;
	localparam int STQ_PTR_W = $clog2(STQ_DEPTH);

	// committed store as seen by memory
	typedef struct packed {
		cpu_isa_pkg::virt_t addr;
		cpu_isa_pkg::uint32_t data;
	} store_req_t;

endpackage

`default_nettype wire

/* verilog/except_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module except_unit (
	input  logic rob_ack,
	input  logic [1:0] head_valid,
	input  cpu_isa_pkg::exc_code_t [1:0] head_exc,
	input  cpu_isa_pkg::virt_t [1:0] head_pc,
	input  logic interrupt_pending,
	output logic except_valid,
	output logic alpha_taken,
	output cpu_isa_pkg::exc_code_t except_code,
	output cpu_isa_pkg::virt_t except_epc
);

	logic [1:0] slot_exc;

	assign slot_exc[0] = head_valid[0] && head_exc[0] != cpu_isa_pkg::EXC_NONE;
	assign slot_exc[1] = head_valid[1] && head_exc[1] != cpu_isa_pkg::EXC_NONE;

	always_comb begin
		except_valid = 1'b0;
		alpha_taken = 1'b0;
		except_code = cpu_isa_pkg::EXC_NONE;
		except_epc = '0;
		if (rob_ack) begin
			if (interrupt_pending) begin
				// interrupt lands before slot 0 executes
				except_valid = 1'b1;
				alpha_taken = 1'b1;
				except_code = cpu_isa_pkg::EXC_INT;
				except_epc = head_pc[0];
			end else if (slot_exc[0]) begin
				except_valid = 1'b1;
				alpha_taken = 1'b1;
				except_code = head_exc[0];
				except_epc = head_pc[0];
			end else if (slot_exc[1]) begin
				except_valid = 1'b1;
				except_code = head_exc[1];
				except_epc = head_pc[1];
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/instr_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_commit (
	// head pair of the ROB
	input  logic [1:0] head_valid,
	input  logic [1:0] head_busy,
	input  cpu_isa_pkg::reg_addr_t [1:0] head_dest,
	input  cpu_isa_pkg::uint32_t [1:0] head_value,
	input  cpu_isa_pkg::fu_t [1:0] head_fu,
	input  cpu_isa_pkg::virt_t [1:0] head_pc,
	input  cpu_isa_pkg::exc_code_t [1:0] head_exc,
	input  cpu_isa_pkg::virt_t [1:0] head_addr,
	input  logic rob_empty,
	input  logic store_full,
	input  logic interrupt_pending,
	output logic rob_ack,
	// register writes
	output logic [1:0] reg_we,
	output cpu_isa_pkg::reg_addr_t [1:0] reg_waddr,
	output cpu_isa_pkg::uint32_t [1:0] reg_wdata,
	// store queue
	output logic store_push,
	output rob_pkg::store_req_t store_req,
	output logic commit_mul,
	output logic commit_cp0,
	// exception
	output logic except_valid,
	output cpu_isa_pkg::exc_code_t except_code,
	output cpu_isa_pkg::virt_t except_epc
);

	logic pair_ready;
	logic alpha_taken;
	logic [1:0] is_store;
	logic [1:0] store_ok;
	logic store_sel;

	// only valid slots can hold the pair back
	assign pair_ready = ~rob_empty & ~|(head_valid & head_busy);

	for (genvar i = 0; i < 2; i++) begin : gen_slot
		assign is_store[i] = head_valid[i] && head_fu[i] == cpu_isa_pkg::FU_STORE;
		assign reg_waddr[i] = head_dest[i];
		assign reg_wdata[i] = head_value[i];
	end

	assign rob_ack = pair_ready & (~|is_store | ~store_full);

	assign reg_we[0] = rob_ack & head_valid[0] & ~(except_valid & alpha_taken);
	assign reg_we[1] = rob_ack & head_valid[1] & ~except_valid;

	// store must be older than the faulting slot
	assign store_ok[0] = is_store[0] & ~(except_valid & alpha_taken);
	assign store_ok[1] = is_store[1] & ~except_valid;
	assign store_sel = store_ok[1];
	assign store_push = rob_ack & |store_ok;
	assign store_req = '{addr: head_addr[store_sel], data: head_value[store_sel]};

	assign commit_mul = rob_ack & head_valid[0] & ~except_valid
		& (head_fu[0] == cpu_isa_pkg::FU_MUL);
	assign commit_cp0 = rob_ack & head_valid[0] & ~except_valid
		& (head_fu[0] == cpu_isa_pkg::FU_CP0);

	except_unit except_inst (
		.rob_ack(rob_ack),
		.head_valid(head_valid),
		.head_exc(head_exc),
		.head_pc(head_pc),
		.interrupt_pending(interrupt_pending),
		.except_valid(except_valid),
		.alpha_taken(alpha_taken),
		.except_code(except_code),
		.except_epc(except_epc)
	);

endmodule

`default_nettype wire

/* verilog/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue #(
	parameter type payload_t = rob_pkg::store_req_t
) (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  payload_t push_data,
	input  logic pop,
	output logic full,
	output logic not_empty,
	output payload_t head_data
);

	payload_t mem_q [rob_pkg::STQ_DEPTH];
	logic [rob_pkg::STQ_PTR_W-1:0] rd_ptr_q;
	logic [rob_pkg::STQ_PTR_W-1:0] wr_ptr_q;
	logic [rob_pkg::STQ_PTR_W:0] count_q;
	logic do_push;
	logic do_pop;

	assign full = count_q == (rob_pkg::STQ_PTR_W + 1)'(rob_pkg::STQ_DEPTH);
	assign not_empty = count_q != '0;
	assign do_push = push & ~full;
	assign do_pop = pop & not_empty;
	assign head_data = mem_q[rd_ptr_q];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (!do_push && do_pop)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem_q[wr_ptr_q] <= push_data;
	end

	push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> !full)
		else $error("store_queue: store push into full queue");

	pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> not_empty)
		else $error("store_queue: pop while empty");

endmodule

`default_nettype wire

/* verilog/arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] we,
	input  cpu_isa_pkg::reg_addr_t [1:0] waddr,
	input  cpu_isa_pkg::uint32_t [1:0] wdata,
	input  cpu_isa_pkg::reg_addr_t raddr,
	output cpu_isa_pkg::uint32_t rdata
);

	cpu_isa_pkg::uint32_t regs_q [cpu_isa_pkg::NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < cpu_isa_pkg::NUM_REGS; r++)
				regs_q[r] <= '0;
		end else begin
			// later slot overrides on a shared address
			for (int i = 0; i < 2; i++) begin
				if (we[i] && waddr[i] != '0)
					regs_q[waddr[i]] <= wdata[i];
			end
		end
	end

	assign rdata = regs_q[raddr];

endmodule

`default_nettype wire

/* verilog/rob.sv */
`timescale 1ns/1ps
`default_nettype none

module rob (
	input  logic clk,
	input  logic rst_n,
	// dispatch
	input  logic dispatch_valid,
	input  logic [1:0] disp_valid,
	input  cpu_isa_pkg::reg_addr_t [1:0] disp_dest,
	input  cpu_isa_pkg::fu_t [1:0] disp_fu,
	input  cpu_isa_pkg::virt_t [1:0] disp_pc,
	input  cpu_isa_pkg::exc_code_t [1:0] disp_exc,
	// writeback
	input  logic wb_valid,
	input  rob_pkg::rob_index_t wb_index,
	input  logic wb_slot,
	input  cpu_isa_pkg::uint32_t wb_value,
	input  cpu_isa_pkg::virt_t wb_addr,
	// commit side
	input  logic rob_ack,
	input  logic flush,
	output logic rob_full,
	output logic rob_empty,
	output rob_pkg::rob_index_t disp_index,
	output logic [1:0] head_valid,
	output logic [1:0] head_busy,
	output cpu_isa_pkg::reg_addr_t [1:0] head_dest,
	output cpu_isa_pkg::uint32_t [1:0] head_value,
	output cpu_isa_pkg::fu_t [1:0] head_fu,
	output cpu_isa_pkg::virt_t [1:0] head_pc,
	output cpu_isa_pkg::exc_code_t [1:0] head_exc,
	output cpu_isa_pkg::virt_t [1:0] head_addr
);

	logic [1:0] valid_q [rob_pkg::ROB_DEPTH];
	logic [1:0] busy_q [rob_pkg::ROB_DEPTH];
	cpu_isa_pkg::reg_addr_t [1:0] dest_q [rob_pkg::ROB_DEPTH];
	cpu_isa_pkg::uint32_t [1:0] value_q [rob_pkg::ROB_DEPTH];
	cpu_isa_pkg::fu_t [1:0] fu_q [rob_pkg::ROB_DEPTH];
	cpu_isa_pkg::virt_t [1:0] pc_q [rob_pkg::ROB_DEPTH];
	cpu_isa_pkg::exc_code_t [1:0] exc_q [rob_pkg::ROB_DEPTH];
	cpu_isa_pkg::virt_t [1:0] addr_q [rob_pkg::ROB_DEPTH];

	rob_pkg::rob_index_t head_q;
	rob_pkg::rob_index_t tail_q;
	logic [rob_pkg::ROB_PTR_W:0] count_q;
	logic do_disp;
	rob_pkg::rob_index_t wb_offset;

	assign rob_full = count_q == (rob_pkg::ROB_PTR_W + 1)'(rob_pkg::ROB_DEPTH);
	assign rob_empty = count_q == '0;
	assign do_disp = dispatch_valid & ~rob_full;
	assign disp_index = tail_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else if (flush) begin
			// exception drops everything in flight
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			if (do_disp)
				tail_q <= tail_q + 1'b1;
			if (rob_ack)
				head_q <= head_q + 1'b1;
			if (do_disp && !rob_ack)
				count_q <= count_q + 1'b1;
			else if (!do_disp && rob_ack)
				count_q <= count_q - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
				valid_q[i] <= '0;
				busy_q[i] <= '0;
			end
		end else begin
			if (do_disp) begin
				valid_q[tail_q] <= disp_valid;
				busy_q[tail_q] <= disp_valid;
			end
			if (wb_valid)
				busy_q[wb_index][wb_slot] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (do_disp) begin
			dest_q[tail_q] <= disp_dest;
			fu_q[tail_q] <= disp_fu;
			pc_q[tail_q] <= disp_pc;
			exc_q[tail_q] <= disp_exc;
		end
		// stores bring their address along with the data
		if (wb_valid) begin
			value_q[wb_index][wb_slot] <= wb_value;
			addr_q[wb_index][wb_slot] <= wb_addr;
		end
	end

	assign head_valid = valid_q[head_q];
	assign head_busy = busy_q[head_q];
	assign head_dest = dest_q[head_q];
	assign head_value = value_q[head_q];
	assign head_fu = fu_q[head_q];
	assign head_pc = pc_q[head_q];
	assign head_exc = exc_q[head_q];
	assign head_addr = addr_q[head_q];

	assign wb_offset = wb_index - head_q;

	disp_not_full: assert property (@(posedge clk) disable iff (!rst_n)
		dispatch_valid |-> !rob_full)
		else $error("rob: dispatch while full");

	wb_in_window: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> ({1'b0, wb_offset} < count_q))
		else $error("rob: writeback to empty index %0d", wb_index);

endmodule

`default_nettype wire

/* verilog/commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_top (
	input  logic clk,
	input  logic rst_n,
	input  logic dispatch_valid,
	input  logic [1:0] disp_valid,
	input  cpu_isa_pkg::reg_addr_t [1:0] disp_dest,
	input  cpu_isa_pkg::fu_t [1:0] disp_fu,
	input  cpu_isa_pkg::virt_t [1:0] disp_pc,
	input  cpu_isa_pkg::exc_code_t [1:0] disp_exc,
	input  logic wb_valid,
	input  rob_pkg::rob_index_t wb_index,
	input  logic wb_slot,
	input  cpu_isa_pkg::uint32_t wb_value,
	input  cpu_isa_pkg::virt_t wb_addr,
	input  logic interrupt_pending,
	input  logic mem_pop,
	input  cpu_isa_pkg::reg_addr_t dbg_raddr,
	output rob_pkg::rob_index_t disp_index,
	output logic rob_full,
	output logic rob_empty,
	output cpu_isa_pkg::uint32_t dbg_rdata,
	output logic mem_store_valid,
	output rob_pkg::store_req_t mem_store_req,
	output logic commit_mul,
	output logic commit_cp0,
	output logic except_valid,
	output cpu_isa_pkg::exc_code_t except_code,
	output cpu_isa_pkg::virt_t except_epc
);

	logic [1:0] head_valid;
	logic [1:0] head_busy;
	cpu_isa_pkg::reg_addr_t [1:0] head_dest;
	cpu_isa_pkg::uint32_t [1:0] head_value;
	cpu_isa_pkg::fu_t [1:0] head_fu;
	cpu_isa_pkg::virt_t [1:0] head_pc;
	cpu_isa_pkg::exc_code_t [1:0] head_exc;
	cpu_isa_pkg::virt_t [1:0] head_addr;
	logic rob_ack;
	logic [1:0] reg_we;
	cpu_isa_pkg::reg_addr_t [1:0] reg_waddr;
	cpu_isa_pkg::uint32_t [1:0] reg_wdata;
	logic store_push;
	rob_pkg::store_req_t store_req;
	logic store_full;

	rob rob_inst (
		.clk(clk),
		.rst_n(rst_n),
		.dispatch_valid(dispatch_valid),
		.disp_valid(disp_valid),
		.disp_dest(disp_dest),
		.disp_fu(disp_fu),
		.disp_pc(disp_pc),
		.disp_exc(disp_exc),
		.wb_valid(wb_valid),
		.wb_index(wb_index),
		.wb_slot(wb_slot),
		.wb_value(wb_value),
		.wb_addr(wb_addr),
		.rob_ack(rob_ack),
		.flush(except_valid),
		.rob_full(rob_full),
		.rob_empty(rob_empty),
		.disp_index(disp_index),
		.head_valid(head_valid),
		.head_busy(head_busy),
		.head_dest(head_dest),
		.head_value(head_value),
		.head_fu(head_fu),
		.head_pc(head_pc),
		.head_exc(head_exc),
		.head_addr(head_addr)
	);

	instr_commit commit_inst (
		.head_valid(head_valid),
		.head_busy(head_busy),
		.head_dest(head_dest),
		.head_value(head_value),
		.head_fu(head_fu),
		.head_pc(head_pc),
		.head_exc(head_exc),
		.head_addr(head_addr),
		.rob_empty(rob_empty),
		.store_full(store_full),
		.interrupt_pending(interrupt_pending),
		.rob_ack(rob_ack),
		.reg_we(reg_we),
		.reg_waddr(reg_waddr),
		.reg_wdata(reg_wdata),
		.store_push(store_push),
		.store_req(store_req),
		.commit_mul(commit_mul),
		.commit_cp0(commit_cp0),
		.except_valid(except_valid),
		.except_code(except_code),
		.except_epc(except_epc)
	);

	store_queue #(
		.payload_t(rob_pkg::store_req_t)
	) stq_inst (
		.clk(clk),
		.rst_n(rst_n),
		.push(store_push),
		.push_data(store_req),
		.pop(mem_pop),
		.full(store_full),
		.not_empty(mem_store_valid),
		.head_data(mem_store_req)
	);

	arch_regfile regfile_inst (
		.clk(clk),
		.rst_n(rst_n),
		.we(reg_we),
		.waddr(reg_waddr),
		.wdata(reg_wdata),
		.raddr(dbg_raddr),
		.rdata(dbg_rdata)
	);

endmodule

`default_nettype wire

/* verification/tb_commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_commit_top;

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int RETIRE_LIMIT = 20;

	logic clk;
	logic rst_n;
	logic dispatch_valid;
	logic [1:0] disp_valid;
	cpu_isa_pkg::reg_addr_t [1:0] disp_dest;
	cpu_isa_pkg::fu_t [1:0] disp_fu;
	cpu_isa_pkg::virt_t [1:0] disp_pc;
	cpu_isa_pkg::exc_code_t [1:0] disp_exc;
	logic wb_valid;
	rob_pkg::rob_index_t wb_index;
	logic wb_slot;
	cpu_isa_pkg::uint32_t wb_value;
	cpu_isa_pkg::virt_t wb_addr;
	logic interrupt_pending;
	logic mem_pop;
	cpu_isa_pkg::reg_addr_t dbg_raddr;
	rob_pkg::rob_index_t disp_index;
	logic rob_full;
	logic rob_empty;
	cpu_isa_pkg::uint32_t dbg_rdata;
	logic mem_store_valid;
	rob_pkg::store_req_t mem_store_req;
	logic commit_mul;
	logic commit_cp0;
	logic except_valid;
	cpu_isa_pkg::exc_code_t except_code;
	cpu_isa_pkg::virt_t except_epc;

	// expected architectural registers
	cpu_isa_pkg::uint32_t reg_model [32];
	logic [31:0] lfsr_q = 32'd32011;
	int cycle_count = 0;
	cpu_isa_pkg::uint32_t val0;
	cpu_isa_pkg::uint32_t val1;
	// events seen while the head pair retires
	logic seen_exc;
	logic seen_mul;
	logic seen_cp0;
	cpu_isa_pkg::exc_code_t seen_code;
	cpu_isa_pkg::virt_t seen_epc;
	rob_pkg::rob_index_t sidx [5];
	cpu_isa_pkg::virt_t st_addr [5];
	cpu_isa_pkg::uint32_t st_data [5];

	commit_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run("timeout: the tests did not finish within the cycle limit");
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected)
			abort_run($sformatf("error: time %0t %s is %0h, expected %0h",
				$time, name, actual, expected));
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output cpu_isa_pkg::uint32_t w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr_q = lfsr_next(lfsr_q);
			w = {w[30:0], lfsr_q[0]};
		end
	endtask

	task automatic dispatch_pair(input logic [1:0] valid,
			input cpu_isa_pkg::reg_addr_t d0, d1, input cpu_isa_pkg::fu_t f0, f1,
			input cpu_isa_pkg::virt_t pc0, input cpu_isa_pkg::exc_code_t e0, e1,
			output rob_pkg::rob_index_t idx);
		@(negedge clk);
		if (rob_full)
			abort_run("dispatch attempted while the reorder buffer is full");
		idx = disp_index;
		@(posedge clk);
		dispatch_valid <= 1'b1;
		disp_valid <= valid;
		disp_dest[0] <= d0;
		disp_dest[1] <= d1;
		disp_fu[0] <= f0;
		disp_fu[1] <= f1;
		disp_pc[0] <= pc0;
		disp_pc[1] <= pc0 + 32'd4;
		disp_exc[0] <= e0;
		disp_exc[1] <= e1;
		@(posedge clk);
		dispatch_valid <= 1'b0;
	endtask

	task automatic writeback(input rob_pkg::rob_index_t idx, input logic slot,
			input cpu_isa_pkg::uint32_t value, input cpu_isa_pkg::virt_t addr);
		@(posedge clk);
		wb_valid <= 1'b1;
		wb_index <= idx;
		wb_slot <= slot;
		wb_value <= value;
		wb_addr <= addr;
		@(posedge clk);
		wb_valid <= 1'b0;
	endtask

	task automatic pop_store(input cpu_isa_pkg::virt_t addr, input cpu_isa_pkg::uint32_t data);
		@(negedge clk);
		check_value("mem_store_valid", mem_store_valid, 1'b1);
		check_value("mem_store_req.addr", mem_store_req.addr, addr);
		check_value("mem_store_req.data", mem_store_req.data, data);
		@(posedge clk);
		mem_pop <= 1'b1;
		@(posedge clk);
		mem_pop <= 1'b0;
	endtask

	task automatic read_reg(input cpu_isa_pkg::reg_addr_t addr,
			input cpu_isa_pkg::uint32_t expected);
		@(posedge clk);
		dbg_raddr <= addr;
		@(negedge clk);
		check_value($sformatf("dbg_rdata[r%0d]", addr), dbg_rdata, expected);
	endtask

	// sample commit outputs until the ROB drains
	task automatic watch_retire();
		int n;
		logic retired;
		seen_exc = 1'b0;
		seen_mul = 1'b0;
		seen_cp0 = 1'b0;
		seen_code = cpu_isa_pkg::EXC_NONE;
		seen_epc = '0;
		n = 0;
		retired = 1'b0;
		while (!retired && n < RETIRE_LIMIT) begin
			@(negedge clk);
			if (except_valid) begin
				seen_exc = 1'b1;
				seen_code = except_code;
				seen_epc = except_epc;
			end
			seen_mul = seen_mul | commit_mul;
			seen_cp0 = seen_cp0 | commit_cp0;
			retired = rob_empty;
			n++;
		end
		if (!retired)
			abort_run("head pair did not leave the reorder buffer in time");
	endtask

	task automatic issue_pair(input cpu_isa_pkg::reg_addr_t d0, d1,
			input cpu_isa_pkg::fu_t f0, f1, input cpu_isa_pkg::virt_t pc0,
			input cpu_isa_pkg::exc_code_t e0, e1, input logic reverse, input int behind);
		rob_pkg::rob_index_t idx;
		rob_pkg::rob_index_t younger;
		dispatch_pair(2'b11, d0, d1, f0, f1, pc0, e0, e1, idx);
		// younger pairs finish early, only a flush keeps them from retiring
		for (int k = 0; k < behind; k++) begin
			dispatch_pair(2'b11, 5'd20, 5'd21, cpu_isa_pkg::FU_ALU, cpu_isa_pkg::FU_ALU,
				pc0 + 32'h100, cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_NONE, younger);
			writeback(younger, 1'b0, 32'hA5A5_0000 + 32'(k), '0);
			writeback(younger, 1'b1, 32'h5A5A_0000 + 32'(k), '0);
		end
		@(negedge clk);
		check_value("rob_full", rob_full, behind + 1 == rob_pkg::ROB_DEPTH);
		rand_word(val0);
		rand_word(val1);
		writeback(idx, reverse, reverse ? val1 : val0, '0);
		// one slot finished is not enough
		@(negedge clk);
		check_value("rob_empty", rob_empty, 1'b0);
		writeback(idx, ~reverse, reverse ? val0 : val1, '0);
		watch_retire();
	endtask

	task automatic expect_retire(input logic exc, input cpu_isa_pkg::exc_code_t code,
			input cpu_isa_pkg::virt_t epc, input logic mul, input logic cp0);
		check_value("except_valid", seen_exc, exc);
		if (exc) begin
			check_value("except_code", seen_code, code);
			check_value("except_epc", seen_epc, epc);
		end
		check_value("commit_mul", seen_mul, mul);
		check_value("commit_cp0", seen_cp0, cp0);
	endtask

	// slot 1 lands last, so it wins a shared destination
	task automatic expect_regs(input cpu_isa_pkg::reg_addr_t d0, d1, input logic w0, w1);
		if (w0 && d0 != '0)
			reg_model[d0] = val0;
		if (w1 && d1 != '0)
			reg_model[d1] = val1;
		read_reg(d0, reg_model[d0]);
		read_reg(d1, reg_model[d1]);
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		check_value("rob_empty", rob_empty, 1'b1);
		check_value("rob_full", rob_full, 1'b0);
		check_value("except_valid", except_valid, 1'b0);
		check_value("commit_mul", commit_mul, 1'b0);
		check_value("commit_cp0", commit_cp0, 1'b0);
		check_value("mem_store_valid", mem_store_valid, 1'b0);
	endtask

	task automatic retire_alu_pairs();
		issue_pair(5'd5, 5'd6, cpu_isa_pkg::FU_ALU, cpu_isa_pkg::FU_ALU, 32'h0040_0000,
			cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_NONE, 1'b1, 0);
		expect_retire(1'b0, cpu_isa_pkg::EXC_NONE, '0, 1'b0, 1'b0);
		expect_regs(5'd5, 5'd6, 1'b1, 1'b1);
		issue_pair(5'd0, 5'd7, cpu_isa_pkg::FU_ALU, cpu_isa_pkg::FU_ALU, 32'h0040_0008,
			cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_NONE, 1'b0, 0);
		expect_retire(1'b0, cpu_isa_pkg::EXC_NONE, '0, 1'b0, 1'b0);
		expect_regs(5'd0, 5'd7, 1'b1, 1'b1);
		issue_pair(5'd9, 5'd9, cpu_isa_pkg::FU_ALU, cpu_isa_pkg::FU_ALU, 32'h0040_0010,
			cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_NONE, 1'b1, 0);
		expect_retire(1'b0, cpu_isa_pkg::EXC_NONE, '0, 1'b0, 1'b0);
		expect_regs(5'd9, 5'd9, 1'b1, 1'b1);
	endtask

	task automatic fill_store_queue();
		for (int i = 0; i < 5; i++) begin
			st_addr[i] = 32'h8000_0100 + 32'(i) * 32'd8;
			rand_word(st_data[i]);
			dispatch_pair(2'b01, 5'd0, 5'd0, cpu_isa_pkg::FU_STORE, cpu_isa_pkg::FU_ALU,
				32'h0040_1000 + 32'(i) * 32'd8, cpu_isa_pkg::EXC_NONE,
				cpu_isa_pkg::EXC_NONE, sidx[i]);
		end
		for (int i = 0; i < 5; i++)
			writeback(sidx[i], 1'b0, st_data[i], st_addr[i]);
		// four stores fill the queue and the fifth pair waits
		repeat (4) @(negedge clk);
		check_value("rob_empty", rob_empty, 1'b0);
		check_value("mem_store_valid", mem_store_valid, 1'b1);
		pop_store(st_addr[0], st_data[0]);
		watch_retire();
		check_value("except_valid", seen_exc, 1'b0);
		for (int i = 1; i < 5; i++)
			pop_store(st_addr[i], st_data[i]);
		@(negedge clk);
		check_value("mem_store_valid", mem_store_valid, 1'b0);
	endtask

	task automatic take_slot_exceptions();
		// overflow in slot 1 with the ROB filled up behind it
		issue_pair(5'd10, 5'd11, cpu_isa_pkg::FU_ALU, cpu_isa_pkg::FU_ALU, 32'h0040_2000,
			cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_OV, 1'b0, rob_pkg::ROB_DEPTH - 1);
		expect_retire(1'b1, cpu_isa_pkg::EXC_OV, 32'h0040_2004, 1'b0, 1'b0);
		expect_regs(5'd10, 5'd11, 1'b1, 1'b0);
		read_reg(5'd20, reg_model[20]);
		issue_pair(5'd14, 5'd15, cpu_isa_pkg::FU_ALU, cpu_isa_pkg::FU_ALU, 32'h0040_3000,
			cpu_isa_pkg::EXC_SYS, cpu_isa_pkg::EXC_NONE, 1'b1, 0);
		expect_retire(1'b1, cpu_isa_pkg::EXC_SYS, 32'h0040_3000, 1'b0, 1'b0);
		expect_regs(5'd14, 5'd15, 1'b0, 1'b0);
	endtask

	task automatic take_interrupt();
		@(posedge clk);
		interrupt_pending <= 1'b1;
		issue_pair(5'd16, 5'd17, cpu_isa_pkg::FU_MUL, cpu_isa_pkg::FU_ALU, 32'h0040_4000,
			cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_NONE, 1'b0, 0);
		expect_retire(1'b1, cpu_isa_pkg::EXC_INT, 32'h0040_4000, 1'b0, 1'b0);
		@(posedge clk);
		interrupt_pending <= 1'b0;
		expect_regs(5'd16, 5'd17, 1'b0, 1'b0);
		issue_pair(5'd16, 5'd17, cpu_isa_pkg::FU_MUL, cpu_isa_pkg::FU_ALU, 32'h0040_4100,
			cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_NONE, 1'b0, 0);
		expect_retire(1'b0, cpu_isa_pkg::EXC_NONE, '0, 1'b1, 1'b0);
		expect_regs(5'd16, 5'd17, 1'b1, 1'b1);
		issue_pair(5'd18, 5'd19, cpu_isa_pkg::FU_CP0, cpu_isa_pkg::FU_ALU, 32'h0040_4200,
			cpu_isa_pkg::EXC_NONE, cpu_isa_pkg::EXC_NONE, 1'b1, 0);
		expect_retire(1'b0, cpu_isa_pkg::EXC_NONE, '0, 1'b0, 1'b1);
		expect_regs(5'd18, 5'd19, 1'b1, 1'b1);
	endtask

	initial begin
		rst_n = 1'b0;
		dispatch_valid = 1'b0;
		disp_valid = '0;
		disp_dest = '0;
		disp_fu[0] = cpu_isa_pkg::FU_ALU;
		disp_fu[1] = cpu_isa_pkg::FU_ALU;
		disp_pc = '0;
		disp_exc[0] = cpu_isa_pkg::EXC_NONE;
		disp_exc[1] = cpu_isa_pkg::EXC_NONE;
		wb_valid = 1'b0;
		wb_index = '0;
		wb_slot = 1'b0;
		wb_value = '0;
		wb_addr = '0;
		interrupt_pending = 1'b0;
		mem_pop = 1'b0;
		dbg_raddr = '0;
		for (int r = 0; r < 32; r++)
			reg_model[r] = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		check_reset_state();
		retire_alu_pairs();
		fill_store_queue();
		take_slot_exceptions();
		take_interrupt();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
verilog/cpu_isa_pkg.sv
verilog/rob_pkg.sv
verilog/except_unit.sv
verilog/instr_commit.sv
verilog/store_queue.sv
verilog/arch_regfile.sv
verilog/rob.sv
verilog/commit_top.sv
verification/tb_commit_top.sv

/* run.sh */
#!/bin/sh
# build and run the commit stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module tb_commit_top \
	--Mdir obj_dir -o tb_commit_top
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_commit_top > sim.log 2>&1
status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
